//--- uart_bus_pkg.sv
/* Register bus types and register map of the UART peripheral.
   Imported by the bus slave and by the RTL top for its port types */
package uart_bus_pkg;

    // Bus geometry
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0]   bus_addr_t;
    typedef logic [DATA_W-1:0]   bus_word_t;
    // One strobe bit per byte lane of the data word
    typedef logic [DATA_W/8-1:0] bus_strb_t;

    ////////////////////////////////////////
    // Register offsets
    ////////////////////////////////////////

    // Control and status, read/write with read-only status bits
    localparam bus_addr_t REG_CTRL = 16'h0000;
    // Baud divider, written per byte strobe
    localparam bus_addr_t REG_DIV  = 16'h0004;
    // TX data, a write blocks while the TX FIFO is full
    localparam bus_addr_t REG_TXD  = 16'h0008;
    // RX data, a read blocks while the RX FIFO is empty
    localparam bus_addr_t REG_RXD  = 16'h000C;

endpackage

//--- uart_frame_pkg.sv
/* Serial frame types shared by the registers, the FIFOs and both line engines.
   Holds the character, divider and bit position types and the engine states */
package uart_frame_pkg;

    // One data character on the line
    typedef logic [7:0]  uart_byte_t;

    // Clock cycles per bit minus one
    typedef logic [15:0] baud_div_t;

    // Position of the current bit within a frame.
    // Start, 8 data, parity and two stops fit in 12 positions
    typedef logic [3:0]  bit_cnt_t;

    // Engine state, shared by the TX and RX engines
    // line_done is a short settling step after a frame
    typedef enum logic [1:0] {
        line_idle = 2'd0,
        line_xfer = 2'd1,
        line_done = 2'd2
    } line_state_t;

endpackage

//--- frame_cfg_if.sv
/* Line configuration bundle, driven by the register block and read by both
   engines */
`timescale 1ns/100ps

interface frame_cfg_if;
    import uart_frame_pkg::*;

    // Engine enable, new frames only start while it is set
    logic      enable;
    // RX listens to the local TX line instead of the pin
    logic      loopback;
    logic      parity_en;
    logic      parity_odd;
    logic      two_stop;
    baud_div_t divider;

    modport ctrl (output enable, loopback, parity_en, parity_odd, two_stop, divider);

    modport engine (input enable, loopback, parity_en, parity_odd, two_stop, divider);

endinterface

//--- sync_fifo.sv
/* Single-clock byte FIFO with first-word fall-through read data.
   Used once for the TX path and once for the RX path */
`timescale 1ns/100ps

module sync_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic                     push,
    input  uart_frame_pkg::uart_byte_t wdata,
    output logic                     full,
    input  logic                     pull,
    output uart_frame_pkg::uart_byte_t rdata,
    output logic                     empty
);
    import uart_frame_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    uart_byte_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pull;

    // Requests against a full or empty FIFO are dropped here
    assign do_push = push && !full;
    assign do_pull = pull && !empty;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    // Oldest entry is always on the output
    assign rdata = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap at the depth, so any depth works
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pull) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pull) begin
                count <= count + 1'b1;
            end else if (do_pull && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Producers and consumers outside must watch the flags
    a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn) !(push && full));
    a_no_pull_empty: assert property (@(posedge aclk) disable iff (!aresetn) !(pull && empty));

endmodule

//--- uart_regs.sv
/* Register bus slave of the UART: control/status, divider, TX and RX data.
   Drives the line configuration and moves bytes in and out of the FIFOs */
`timescale 1ns/100ps

module uart_regs #(
    parameter int DEFAULT_DIVIDER = 3
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    // Register bus
    input  logic                       en,
    input  logic                       wr,
    input  uart_bus_pkg::bus_addr_t    addr,
    input  uart_bus_pkg::bus_word_t    wdata,
    input  uart_bus_pkg::bus_strb_t    strb,
    output uart_bus_pkg::bus_word_t    rdata,
    output logic                       ready,
    // TX FIFO write side
    output logic                       tx_push,
    output uart_frame_pkg::uart_byte_t tx_byte,
    input  logic                       tx_full,
    input  logic                       tx_empty,
    // RX FIFO read side
    output logic                       rx_pull,
    input  uart_frame_pkg::uart_byte_t rx_byte,
    input  logic                       rx_full,
    input  logic                       rx_empty,
    // Engine status
    input  logic                       tx_busy,
    input  logic                       rx_busy,
    input  logic                       cts_sync,
    input  logic                       parity_err,
    frame_cfg_if.ctrl                  cfg
);
    import uart_bus_pkg::*;
    import uart_frame_pkg::*;

    // Control bits in register order: two_stop down to enable
    logic [4:0] ctrl_q;
    baud_div_t  divider_q;
    bus_word_t  status;
    logic       access;
    logic       done;

    assign cfg.enable     = ctrl_q[0];
    assign cfg.loopback   = ctrl_q[1];
    assign cfg.parity_en  = ctrl_q[2];
    assign cfg.parity_odd = ctrl_q[3];
    assign cfg.two_stop   = ctrl_q[4];
    assign cfg.divider    = divider_q;

    // Status sits in bits 15:8 above the control bits, upper half reads zero
    assign status = bus_word_t'({parity_err, cts_sync, ~rx_full, rx_full, rx_empty,
                                 tx_full, tx_empty, tx_busy | rx_busy, 3'b000, ctrl_q});

    ////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////

    // The cycle after ready is a dead cycle, a held en is not a new request
    assign access = en && !ready;

    // Data registers complete only once their FIFO can serve the access
    always_comb begin
        case (addr)
            REG_TXD: done = !wr || !tx_full;
            REG_RXD: done = wr || !rx_empty;
            default: done = 1'b1;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ready     <= 1'b0;
            tx_push   <= 1'b0;
            rx_pull   <= 1'b0;
            ctrl_q    <= 5'b00001;
            divider_q <= baud_div_t'(DEFAULT_DIVIDER);
        end else begin
            ready   <= access && done;
            // FIFO strobes line up with ready, the flags settle in the dead cycle
            tx_push <= access && done && wr && (addr == REG_TXD);
            rx_pull <= access && done && !wr && (addr == REG_RXD);
            if (access && wr && (addr == REG_CTRL) && strb[0]) begin
                ctrl_q <= wdata[4:0];
            end
            if (access && wr && (addr == REG_DIV)) begin
                if (strb[0]) divider_q[7:0]  <= wdata[7:0];
                if (strb[1]) divider_q[15:8] <= wdata[15:8];
            end
        end
    end

    // Read data and TX byte are only looked at together with ready or tx_push
    always_ff @(posedge aclk) begin
        if (access && done) begin
            case (addr)
                REG_CTRL: rdata <= status;
                REG_DIV:  rdata <= bus_word_t'(divider_q);
                REG_TXD:  rdata <= bus_word_t'(tx_byte);
                REG_RXD:  rdata <= bus_word_t'(rx_byte);
                default:  rdata <= '1;
            endcase
            if (wr && (addr == REG_TXD)) begin
                tx_byte <= wdata[7:0];
            end
        end
    end

    // A completed read of a readable register returns fully known data
    a_read_known: assert property (@(posedge aclk) disable iff (!aresetn)
        ready && !$past(wr) && ($past(addr) != REG_TXD) |-> !$isunknown(rdata));

endmodule

//--- uart_tx.sv
/* Transmit engine: takes bytes from the TX FIFO and serializes them with
   optional parity and one or two stop bits while CTS allows it */
`timescale 1ns/100ps

module uart_tx (
    input  logic                       aclk,
    input  logic                       aresetn,
    frame_cfg_if.engine                cfg,
    input  logic                       uart_cts,
    input  uart_frame_pkg::uart_byte_t byte_in,
    input  logic                       empty,
    output logic                       pull,
    output logic                       uart_tx,
    output logic                       cts_sync,
    output logic                       busy
);
    import uart_frame_pkg::*;

    line_state_t state;
    logic [1:0]  cts_q;
    baud_div_t   baud_cnt;
    bit_cnt_t    bit_cnt;
    bit_cnt_t    last_bit;
    uart_byte_t  shift_q;
    logic        parity_q;
    logic        start;
    logic        bit_tick;

    assign cts_sync = cts_q[1];
    assign busy     = (state != line_idle);

    // A frame only starts between frames, so CTS and enable never cut one
    assign start    = (state == line_idle) && cfg.enable && cts_sync && !empty;
    assign bit_tick = (state == line_xfer) && (baud_cnt == cfg.divider);
    // Index of the final stop bit: start is 0, data 1 to 8
    assign last_bit = bit_cnt_t'(9) + bit_cnt_t'(cfg.parity_en) + bit_cnt_t'(cfg.two_stop);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cts_q <= 2'b11;
        end else begin
            cts_q <= {cts_q[0], uart_cts};
        end
    end

    // Byte and parity are captured when the frame starts
    always_ff @(posedge aclk) begin
        if (start) begin
            shift_q  <= byte_in;
            parity_q <= (^byte_in) ^ cfg.parity_odd;
        end else if (bit_tick && (bit_cnt < bit_cnt_t'(8))) begin
            shift_q  <= shift_q >> 1;
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= line_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            pull     <= 1'b0;
            uart_tx  <= 1'b1;
        end else begin
            pull <= start;
            case (state)
                line_xfer: begin
                    baud_cnt <= bit_tick ? '0 : baud_cnt + 1'b1;
                    if (bit_tick) begin
                        if (bit_cnt == last_bit) begin
                            state <= line_done;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            // Next bit: data LSB first, then parity, then stops
                            if (bit_cnt < bit_cnt_t'(8)) begin
                                uart_tx <= shift_q[0];
                            end else if ((bit_cnt == bit_cnt_t'(8)) && cfg.parity_en) begin
                                uart_tx <= parity_q;
                            end else begin
                                uart_tx <= 1'b1;
                            end
                        end
                    end
                end
                line_done: begin
                    state <= line_idle;
                end
                default: begin
                    uart_tx  <= 1'b1;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (start) begin
                        uart_tx <= 1'b0;
                        state   <= line_xfer;
                    end
                end
            endcase
        end
    end

endmodule

//--- uart_rx.sv
/* Receive engine: synchronizes the serial line (or the local TX line in
   loopback), deserializes bytes, checks parity and pushes into the RX FIFO */
`timescale 1ns/100ps

module uart_rx (
    input  logic                       aclk,
    input  logic                       aresetn,
    frame_cfg_if.engine                cfg,
    input  logic                       uart_rx,
    input  logic                       tx_line,
    input  logic                       rts,
    output logic                       push,
    output uart_frame_pkg::uart_byte_t byte_out,
    output logic                       parity_err,
    output logic                       busy
);
    import uart_frame_pkg::*;

    line_state_t state;
    logic [1:0]  line_q;
    logic        rx_bit;
    baud_div_t   baud_cnt;
    bit_cnt_t    bit_cnt;
    logic        bit_tick;
    logic        last_data;

    assign rx_bit    = line_q[1];
    assign busy      = (state != line_idle);
    assign bit_tick  = (state == line_xfer) && (baud_cnt == cfg.divider);
    // Data bit 7 ends the frame unless a parity bit follows
    assign last_data = (bit_cnt == bit_cnt_t'(7)) && !cfg.parity_en;

    // Two-flop synchronizer on the selected line, idle level is high
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            line_q <= 2'b11;
        end else begin
            line_q <= {line_q[0], cfg.loopback ? tx_line : uart_rx};
        end
    end

    always_ff @(posedge aclk) begin
        if (bit_tick && (bit_cnt < bit_cnt_t'(8))) begin
            byte_out <= {rx_bit, byte_out[7:1]};
        end
    end

    ////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state      <= line_idle;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            push       <= 1'b0;
            parity_err <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                line_xfer: begin
                    baud_cnt <= bit_tick ? '0 : baud_cnt + 1'b1;
                    if (bit_tick) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_data) begin
                            push       <= 1'b1;
                            parity_err <= 1'b0;
                            state      <= line_done;
                        end else if (bit_cnt == bit_cnt_t'(8)) begin
                            // Data and parity together must match the parity mode
                            push       <= 1'b1;
                            parity_err <= (^byte_out) ^ rx_bit ^ cfg.parity_odd;
                            state      <= line_done;
                        end
                    end
                end
                line_done: begin
                    // The last bit may be low, wait for the stop level first
                    if (rx_bit) begin
                        state <= line_idle;
                    end
                end
                default: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (cfg.enable && rts && !rx_bit) begin
                        state <= line_xfer;
                    end
                end
            endcase
        end
    end

endmodule

//--- uart_top.sv
/* RTL top of the UART peripheral: register slave, two byte FIFOs and the
   TX and RX engines behind plain bus and line ports */
`timescale 1ns/100ps

module uart_top #(
    parameter int FIFO_DEPTH      = 4,
    parameter int DEFAULT_DIVIDER = 3
) (
    input  logic                    aclk,
    input  logic                    aresetn,
    input  logic                    en,
    input  logic                    wr,
    input  uart_bus_pkg::bus_addr_t addr,
    input  uart_bus_pkg::bus_word_t wdata,
    input  uart_bus_pkg::bus_strb_t strb,
    output uart_bus_pkg::bus_word_t rdata,
    output logic                    ready,
    input  logic                    uart_rx,
    output logic                    uart_tx,
    output logic                    uart_rts,
    input  logic                    uart_cts
);
    import uart_frame_pkg::*;

    logic       tx_push, tx_pull, tx_full, tx_empty, tx_busy, cts_sync;
    logic       rx_push, rx_pull, rx_full, rx_empty, rx_busy, parity_err;
    uart_byte_t tx_wbyte, tx_rbyte, rx_wbyte, rx_rbyte;

    frame_cfg_if cfg_if ();

    // Peer may send while the RX FIFO has room
    assign uart_rts = ~rx_full;

    uart_regs #(.DEFAULT_DIVIDER(DEFAULT_DIVIDER)) regs_i (
        .aclk(aclk), .aresetn(aresetn), .en(en), .wr(wr), .addr(addr), .wdata(wdata),
        .strb(strb), .rdata(rdata), .ready(ready), .tx_push(tx_push), .tx_byte(tx_wbyte),
        .tx_full(tx_full), .tx_empty(tx_empty), .rx_pull(rx_pull), .rx_byte(rx_rbyte),
        .rx_full(rx_full), .rx_empty(rx_empty), .tx_busy(tx_busy), .rx_busy(rx_busy),
        .cts_sync(cts_sync), .parity_err(parity_err), .cfg(cfg_if.ctrl)
    );

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
        .aclk(aclk), .aresetn(aresetn), .push(tx_push), .wdata(tx_wbyte), .full(tx_full),
        .pull(tx_pull), .rdata(tx_rbyte), .empty(tx_empty)
    );

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .aclk(aclk), .aresetn(aresetn), .push(rx_push), .wdata(rx_wbyte), .full(rx_full),
        .pull(rx_pull), .rdata(rx_rbyte), .empty(rx_empty)
    );

    uart_tx tx_i (
        .aclk(aclk), .aresetn(aresetn), .cfg(cfg_if.engine), .uart_cts(uart_cts),
        .byte_in(tx_rbyte), .empty(tx_empty), .pull(tx_pull), .uart_tx(uart_tx),
        .cts_sync(cts_sync), .busy(tx_busy)
    );

    // Loopback taps the TX line right at the output port
    uart_rx rx_i (
        .aclk(aclk), .aresetn(aresetn), .cfg(cfg_if.engine), .uart_rx(uart_rx),
        .tx_line(uart_tx), .rts(uart_rts), .push(rx_push), .byte_out(rx_wbyte),
        .parity_err(parity_err), .busy(rx_busy)
    );

endmodule

//--- tb_uart.sv
/* Directed testbench for the UART peripheral. Drives the register bus and the
   serial pins, then checks registers, frames, FIFO order and flow control */
`timescale 1ns/100ps

module tb_uart;
    import uart_bus_pkg::*;
    import uart_frame_pkg::*;

    localparam int FIFO_DEPTH      = 4;
    localparam int DEFAULT_DIVIDER = 3;
    // Roughly twice the longest test sequence
    localparam int MAX_CYCLES      = 20000;
    localparam int LOOP_BYTES      = 6;
    localparam bus_addr_t UNMAPPED = 16'h0010;

    // Status bit positions in the control/status register
    localparam int B_BUSY     = 8;
    localparam int B_TX_EMPTY = 9;
    localparam int B_RX_EMPTY = 11;
    localparam int B_RX_FULL  = 12;
    localparam int B_RTS      = 13;
    localparam int B_CTS      = 14;
    localparam int B_PAR_ERR  = 15;

    logic      aclk;
    logic      aresetn;
    logic      en;
    logic      wr;
    bus_addr_t addr;
    bus_word_t wdata;
    bus_strb_t strb;
    bus_word_t rdata;
    logic      ready;
    logic      uart_rx;
    logic      uart_tx;
    logic      uart_rts;
    logic      uart_cts;

    integer    seed = 32'haa42_c03d;
    int        cycles = 0;
    // Line configuration as last written to the DUT
    logic      par_en;
    logic      par_odd;
    logic      two_stop;
    baud_div_t div_cfg;

    uart_top #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .DEFAULT_DIVIDER(DEFAULT_DIVIDER)
    ) dut_i (
        .aclk(aclk), .aresetn(aresetn), .en(en), .wr(wr), .addr(addr), .wdata(wdata),
        .strb(strb), .rdata(rdata), .ready(ready), .uart_rx(uart_rx), .uart_tx(uart_tx),
        .uart_rts(uart_rts), .uart_cts(uart_cts)
    );

    always #2 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input bus_word_t got, input bus_word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // Single line levels and status flags
    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////
    // Bus and line drivers
    ////////////////////////////////////////

    // Outputs are read right after the edge, so they hold the value of the cycle before
    task automatic bus_write(input bus_addr_t a, input bus_word_t d, input bus_strb_t s);
        @(posedge aclk);
        en    <= 1'b1;
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        strb  <= s;
        @(posedge aclk);
        while (!ready) @(posedge aclk);
        en <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t a, output bus_word_t d);
        @(posedge aclk);
        en   <= 1'b1;
        wr   <= 1'b0;
        addr <= a;
        strb <= '0;
        @(posedge aclk);
        while (!ready) @(posedge aclk);
        d  = rdata;
        en <= 1'b0;
    endtask

    task automatic set_ctrl(input logic [4:0] c);
        bus_write(REG_CTRL, bus_word_t'(c), 4'b0001);
        par_en   = c[2];
        par_odd  = c[3];
        two_stop = c[4];
    endtask

    // Start, 8 data bits, optional parity, one or two stops
    function automatic int frame_len();
        return 10 + int'(par_en) + int'(two_stop);
    endfunction

    // Expected frame, bit 0 goes first on the line; flip corrupts the parity bit
    function automatic logic [11:0] frame_bits(input uart_byte_t b, input logic flip);
        logic [11:0] f;
        f      = '1;
        f[0]   = 1'b0;
        f[8:1] = b;
        if (par_en) begin
            f[9] = (^b) ^ par_odd ^ flip;
        end
        return f;
    endfunction

    task automatic send_frame(input uart_byte_t b, input logic flip);
        logic [11:0] f;
        f = frame_bits(b, flip);
        @(posedge aclk);
        for (int i = 0; i < frame_len(); i++) begin
            uart_rx <= f[i];
            repeat (int'(div_cfg) + 1) @(posedge aclk);
        end
    endtask

    task automatic sample_frame(output logic [11:0] got);
        int period;
        period = int'(div_cfg) + 1;
        got    = '1;
        @(posedge aclk);
        while (uart_tx) @(posedge aclk);
        // The start bit began one edge ago, move to its middle
        repeat (period / 2 - 1) @(posedge aclk);
        got[0] = uart_tx;
        for (int i = 1; i < frame_len(); i++) begin
            repeat (period) @(posedge aclk);
            got[i] = uart_tx;
        end
    endtask

    task automatic expect_tx_frame(input uart_byte_t b);
        logic [11:0] got;
        logic [11:0] exp;
        sample_frame(got);
        exp = frame_bits(b, 1'b0);
        for (int i = 0; i < frame_len(); i++) begin
            check_bit(got[i], exp[i], $sformatf("uart_tx bit %0d of frame %h", i, b));
        end
    endtask

    task automatic wait_idle();
        bus_word_t st;
        bus_read(REG_CTRL, st);
        while (st[B_BUSY]) bus_read(REG_CTRL, st);
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset();
        bus_word_t rd;
        bus_word_t exp;
        exp             = '0;
        exp[0]          = 1'b1;
        exp[B_TX_EMPTY] = 1'b1;
        exp[B_RX_EMPTY] = 1'b1;
        exp[B_RTS]      = 1'b1;
        exp[B_CTS]      = 1'b1;
        bus_read(REG_CTRL, rd);
        check_word(rd, exp, "status after reset");
        bus_read(REG_DIV, rd);
        check_word(rd, bus_word_t'(DEFAULT_DIVIDER), "divider after reset");
        bus_read(UNMAPPED, rd);
        check_word(rd, '1, "unmapped read");
    endtask

    task automatic test_regs();
        bus_word_t rd;
        // Only byte 1 is strobed, byte 0 keeps its reset value
        bus_write(REG_DIV, 32'h1234_ab55, 4'b0010);
        bus_read(REG_DIV, rd);
        check_word(rd, 32'h0000_ab03, "divider after byte 1 write");
        bus_write(REG_DIV, bus_word_t'(DEFAULT_DIVIDER), 4'b0011);
        bus_read(REG_DIV, rd);
        check_word(rd, bus_word_t'(DEFAULT_DIVIDER), "divider restored");
        bus_write(REG_CTRL, 32'h0000_001e, 4'b1110);
        bus_read(REG_CTRL, rd);
        check_word(bus_word_t'(rd[4:0]), 32'h1, "control after write without strobe 0");
    endtask

    task automatic test_tx();
        uart_byte_t b;
        for (int pass = 0; pass < 2; pass++) begin
            // Second pass runs odd parity with two stop bits
            if (pass == 1) begin
                wait_idle();
                set_ctrl(5'b11101);
            end
            for (int i = 0; i < 3; i++) begin
                b = uart_byte_t'($random(seed));
                bus_write(REG_TXD, bus_word_t'(b), 4'b0001);
                expect_tx_frame(b);
            end
        end
        wait_idle();
    endtask

    task automatic rx_round(input logic flip);
        uart_byte_t b;
        bus_word_t  rd;
        b = uart_byte_t'($random(seed));
        send_frame(b, flip);
        bus_read(REG_RXD, rd);
        check_byte(rd[7:0], b, "byte read from RX data");
        bus_read(REG_CTRL, rd);
        check_bit(rd[B_PAR_ERR], flip, "rx parity error flag");
    endtask

    task automatic test_rx();
        // Even parity, a bad frame in the middle
        set_ctrl(5'b00101);
        rx_round(1'b0);
        rx_round(1'b1);
        rx_round(1'b0);
    endtask

    task automatic test_loopback();
        uart_byte_t data [LOOP_BYTES];
        bus_word_t  rd;
        set_ctrl(5'b00011);
        // More bytes than the TX FIFO holds, so the last writes stall
        for (int i = 0; i < LOOP_BYTES; i++) begin
            data[i] = uart_byte_t'($random(seed));
            bus_write(REG_TXD, bus_word_t'(data[i]), 4'b0001);
        end
        for (int i = 0; i < LOOP_BYTES; i++) begin
            bus_read(REG_RXD, rd);
            check_byte(rd[7:0], data[i], $sformatf("loopback byte %0d", i));
        end
        wait_idle();
        set_ctrl(5'b00001);
    endtask

    task automatic test_flow();
        uart_byte_t b;
        uart_byte_t data [FIFO_DEPTH];
        bus_word_t  rd;
        @(posedge aclk);
        uart_cts <= 1'b0;
        // Two synchronizer stages before the engine sees CTS
        repeat (3) @(posedge aclk);
        b = uart_byte_t'($random(seed));
        bus_write(REG_TXD, bus_word_t'(b), 4'b0001);
        repeat (6 * (int'(div_cfg) + 1)) begin
            @(posedge aclk);
            check_bit(uart_tx, 1'b1, "uart_tx while CTS low");
        end
        bus_read(REG_CTRL, rd);
        check_bit(rd[B_TX_EMPTY], 1'b0, "tx_empty while CTS low");
        check_bit(rd[B_CTS], 1'b0, "cts_sync while CTS low");
        @(posedge aclk);
        uart_cts <= 1'b1;
        expect_tx_frame(b);
        // Fill the RX FIFO from the pin until RTS drops
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            data[i] = uart_byte_t'($random(seed));
            send_frame(data[i], 1'b0);
        end
        check_bit(uart_rts, 1'b0, "uart_rts with RX FIFO full");
        bus_read(REG_CTRL, rd);
        check_bit(rd[B_RX_FULL], 1'b1, "rx_full status");
        bus_read(REG_RXD, rd);
        check_byte(rd[7:0], data[0], "first byte of full RX FIFO");
        bus_read(REG_CTRL, rd);
        check_bit(rd[B_RTS], 1'b1, "rts status after one read");
        check_bit(uart_rts, 1'b1, "uart_rts after one read");
        for (int i = 1; i < FIFO_DEPTH; i++) begin
            bus_read(REG_RXD, rd);
            check_byte(rd[7:0], data[i], $sformatf("RX FIFO byte %0d", i));
        end
    endtask

    initial begin
        aclk     = 1'b0;
        aresetn  = 1'b0;
        en       = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        wdata    = '0;
        strb     = '0;
        uart_rx  = 1'b1;
        uart_cts = 1'b1;
        par_en   = 1'b0;
        par_odd  = 1'b0;
        two_stop = 1'b0;
        div_cfg  = baud_div_t'(DEFAULT_DIVIDER);
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;
        test_reset();
        test_regs();
        test_tx();
        test_rx();
        test_loopback();
        test_flow();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- uart.f
uart_bus_pkg.sv
uart_frame_pkg.sv
frame_cfg_if.sv
sync_fifo.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart.sv

//--- Makefile
# Verilator build and run of the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uart
FLIST     ?= uart.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
